//--- rtl/mergePkg.sv
`default_nettype none

package mergePkg;

    localparam int DataW    = 32;
    localparam int NumLanes = 16;
    localparam int LaneIdxW = 4;
    localparam int DelayW   = 16;
    localparam int AddrW    = 8;
    localparam int StrbW    = DataW / 8;
    localparam int CountW   = 5;  // Wide enough to hold NumLanes itself.

    localparam logic [AddrW-1:0] RegCtrl     = 8'h00;
    localparam logic [AddrW-1:0] RegDelay    = 8'h04;
    localparam logic [AddrW-1:0] RegStatus   = 8'h08;
    localparam logic [AddrW-1:0] RegCount    = 8'h0C;
    localparam logic [AddrW-1:0] RegChecksum = 8'h10;

    localparam logic [1:0] RespOkay   = 2'b00;
    localparam logic [1:0] RespSlvErr = 2'b10;

    // Lane k lives at index k.
    typedef logic [NumLanes-1:0][DataW-1:0] laneVecT;

    typedef struct packed {
        logic              start;
        logic [DelayW-1:0] delay;
    } mergeCfgT;

    typedef struct packed {
        logic              busy;
        logic              done;
        logic [CountW-1:0] count;
        logic [DataW-1:0]  checksum;
    } mergeStatT;

    typedef struct packed {
        logic [AddrW-1:0] awaddr;
        logic             awvalid;
        logic [DataW-1:0] wdata;
        logic [StrbW-1:0] wstrb;
        logic             wvalid;
        logic             bready;
        logic [AddrW-1:0] araddr;
        logic             arvalid;
        logic             rready;
    } axiLiteReqT;

    typedef struct packed {
        logic             awready;
        logic             wready;
        logic [1:0]       bresp;
        logic             bvalid;
        logic             arready;
        logic [DataW-1:0] rdata;
        logic [1:0]       rresp;
        logic             rvalid;
    } axiLiteRspT;

    typedef enum logic [1:0] {Idle, Wait, Emit} mergeStateT;
    typedef enum logic {WrIdle, WrResp} axiWrStateT;
    typedef enum logic {RdIdle, RdResp} axiRdStateT;

endpackage

`default_nettype wire

//--- rtl/mergeRegs.sv
`timescale 1ns/1ns
`default_nettype none

module mergeRegs (
    input  wire                  clk,
    input  wire                  rst,
    input  wire mergePkg::axiLiteReqT axiReq,
    output mergePkg::axiLiteRspT axiRsp,
    input  wire                  busy,
    input  wire mergePkg::mergeStatT  stat,
    output mergePkg::mergeCfgT   cfg
);
    import mergePkg::*;

    axiWrStateT        wrState;
    axiRdStateT        rdState;
    logic [DelayW-1:0] delayReg;
    logic              startPend;
    logic              startReg;
    logic [1:0]        bresp;
    logic [1:0]        rresp;
    logic [DataW-1:0]  rdata;
    logic              wrAccept;
    logic              rdAccept;
    logic              wrMapped;
    logic              rdMapped;
    logic [DataW-1:0]  rdMux;

    // Address and data are taken together, one write at a time.
    assign wrAccept = (wrState == WrIdle) && axiReq.awvalid && axiReq.wvalid;
    assign rdAccept = (rdState == RdIdle) && axiReq.arvalid;

    always_comb begin
        case (axiReq.awaddr)
            RegCtrl, RegDelay, RegStatus, RegCount, RegChecksum: wrMapped = 1'b1;
            default: wrMapped = 1'b0;
        endcase
    end

    always_comb begin
        rdMapped = 1'b1;
        rdMux    = '0;
        case (axiReq.araddr)
            RegCtrl:     rdMux = '0;  // Control is write-only and reads as zero.
            RegDelay:    rdMux = DataW'(delayReg);
            RegStatus:   rdMux = DataW'({stat.done, busy});
            RegCount:    rdMux = DataW'(stat.count);
            RegChecksum: rdMux = stat.checksum;
            default:     rdMapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrState <= WrIdle;
            bresp   <= RespOkay;
        end else begin
            case (wrState)
                WrIdle: begin
                    if (wrAccept) begin
                        wrState <= WrResp;
                        bresp   <= wrMapped ? RespOkay : RespSlvErr;
                    end
                end
                WrResp: begin
                    if (axiReq.bready) begin
                        wrState <= WrIdle;
                    end
                end
                default: wrState <= WrIdle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            delayReg <= '0;
        end else if (wrAccept && axiReq.awaddr == RegDelay) begin
            // Only the two low byte lanes exist in this register.
            for (int b = 0; b < DelayW / 8; b++) begin
                if (axiReq.wstrb[b]) begin
                    delayReg[b*8 +: 8] <= axiReq.wdata[b*8 +: 8];
                end
            end
        end
    end

    // The start request is held one edge, so the pulse appears one cycle after acceptance.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            startPend <= 1'b0;
            startReg  <= 1'b0;
        end else begin
            startPend <= wrAccept && (axiReq.awaddr == RegCtrl) && axiReq.wdata[0];
            startReg  <= startPend;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdState <= RdIdle;
            rresp   <= RespOkay;
        end else begin
            case (rdState)
                RdIdle: begin
                    if (rdAccept) begin
                        rdState <= RdResp;
                        rresp   <= rdMapped ? RespOkay : RespSlvErr;
                    end
                end
                RdResp: begin
                    if (axiReq.rready) begin
                        rdState <= RdIdle;
                    end
                end
                default: rdState <= RdIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rdata <= rdMux;  // Unmapped addresses already give zero here.
        end
    end

    always_comb begin
        axiRsp         = '0;
        axiRsp.awready = wrAccept;
        axiRsp.wready  = wrAccept;
        axiRsp.bresp   = bresp;
        axiRsp.bvalid  = (wrState == WrResp);
        axiRsp.arready = (rdState == RdIdle);
        axiRsp.rdata   = rdata;
        axiRsp.rresp   = rresp;
        axiRsp.rvalid  = (rdState == RdResp);
    end

    assign cfg = '{start: startReg, delay: delayReg};

    bHeldUntilReady: assert property (@(posedge clk) disable iff (rst)
        axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid && $stable(axiRsp.bresp))
        else $error("Write response dropped before bready.");

endmodule

`default_nettype wire

//--- rtl/skewLine.sv
`timescale 1ns/1ns
`default_nettype none

module skewLine (
    input  wire                    clk,
    input  wire                    rst,
    input  wire mergePkg::laneVecT lanes,
    output mergePkg::laneVecT      skewed
);
    import mergePkg::*;

    // Lane 0 has no delay at all.
    assign skewed[0] = lanes[0];

    // Lane k runs through k registers, so the lanes form a triangle of
    // 1 + 2 + ... + 15 stages.
    for (genvar k = 1; k < NumLanes; k++) begin : gLane
        logic [DataW-1:0] taps [k];

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                for (int i = 0; i < k; i++) begin
                    taps[i] <= '0;
                end
            end else begin
                taps[0] <= lanes[k];
                for (int i = 1; i < k; i++) begin
                    taps[i] <= taps[i-1];
                end
            end
        end

        assign skewed[k] = taps[k-1];  // Oldest stage feeds the merge unit.
    end

endmodule

`default_nettype wire

//--- rtl/laneMerge.sv
`timescale 1ns/1ns
`default_nettype none

module laneMerge (
    input  wire                        clk,
    input  wire                        rst,
    input  wire mergePkg::mergeCfgT    cfg,
    input  wire mergePkg::laneVecT     skewed,
    output logic [mergePkg::DataW-1:0] outData,
    output logic                       outValid,
    output logic                       busy
);
    import mergePkg::*;

    mergeStateT          state;
    logic [DelayW-1:0]   delayCnt;
    logic [LaneIdxW-1:0] laneCnt;
    logic                lastLane;

    assign lastLane = (laneCnt == LaneIdxW'(NumLanes - 1));
    assign busy     = (state != Idle);

    // With delay d the unit waits d cycles and then spends one edge per lane.
    // A zero delay goes straight to Emit.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= Idle;
            delayCnt <= '0;
            laneCnt  <= '0;
            outValid <= 1'b0;
        end else if (cfg.start) begin
            state    <= (cfg.delay == '0) ? Emit : Wait;
            delayCnt <= cfg.delay - 1'b1;  // Unused when the delay is zero.
            laneCnt  <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= 1'b0;
            case (state)
                Wait: begin
                    if (delayCnt == '0) begin
                        state <= Emit;
                    end else begin
                        delayCnt <= delayCnt - 1'b1;
                    end
                end
                Emit: begin
                    outValid <= 1'b1;
                    laneCnt  <= laneCnt + 1'b1;
                    if (lastLane) begin
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // The skew line has already aligned lane k with this edge.
    always_ff @(posedge clk) begin
        if (state == Emit && !cfg.start) begin
            outData <= skewed[laneCnt];
        end
    end

    validOnlyFromEmit: assert property (@(posedge clk) disable iff (rst)
        outValid |-> $past(state) == Emit)
        else $error("outValid raised without an Emit cycle.");

    noLaneWrap: assert property (@(posedge clk) disable iff (rst)
        state == Emit && !cfg.start |=> state != Emit || laneCnt != '0)
        else $error("Lane counter wrapped while emitting.");

endmodule

`default_nettype wire

//--- rtl/sweepMonitor.sv
`timescale 1ns/1ns
`default_nettype none

module sweepMonitor (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        start,
    input  wire [mergePkg::DataW-1:0]  outData,
    input  wire                        outValid,
    output mergePkg::mergeStatT        stat
);
    import mergePkg::*;

    logic [CountW-1:0] count;
    logic [DataW-1:0]  checksum;
    logic              done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count    <= '0;
            checksum <= '0;
            done     <= 1'b0;
        end else if (start) begin
            count    <= '0;
            checksum <= '0;
            done     <= 1'b0;
        end else if (outValid) begin
            count    <= count + 1'b1;
            checksum <= checksum + outData;  // Wraps modulo 2^32.
            if (count == CountW'(NumLanes - 1)) begin
                done <= 1'b1;
            end
        end
    end

    // Busy is reported by the merge unit, not here.
    assign stat = '{busy: 1'b0, done: done, count: count, checksum: checksum};

    countInRange: assert property (@(posedge clk) disable iff (rst)
        count <= CountW'(NumLanes))
        else $error("More words seen than there are lanes.");

endmodule

`default_nettype wire

//--- rtl/mergeTop.sv
`timescale 1ns/1ns
`default_nettype none

module mergeTop (
    input  wire                        clk,
    input  wire                        rst,
    input  wire mergePkg::axiLiteReqT  axiReq,
    output mergePkg::axiLiteRspT       axiRsp,
    input  wire mergePkg::laneVecT     lanes,
    output logic [mergePkg::DataW-1:0] outData,
    output logic                       outValid
);
    import mergePkg::*;

    mergeCfgT  cfg;
    mergeStatT stat;
    laneVecT   skewed;
    logic      busy;

    mergeRegs regs0 (
        .clk    (clk),
        .rst    (rst),
        .axiReq (axiReq),
        .axiRsp (axiRsp),
        .busy   (busy),
        .stat   (stat),
        .cfg    (cfg)
    );

    skewLine skew0 (
        .clk    (clk),
        .rst    (rst),
        .lanes  (lanes),
        .skewed (skewed)
    );

    laneMerge merge0 (
        .clk      (clk),
        .rst      (rst),
        .cfg      (cfg),
        .skewed   (skewed),
        .outData  (outData),
        .outValid (outValid),
        .busy     (busy)
    );

    // The monitor watches the same stream that leaves the top.
    sweepMonitor monitor0 (
        .clk      (clk),
        .rst      (rst),
        .start    (cfg.start),
        .outData  (outData),
        .outValid (outValid),
        .stat     (stat)
    );

endmodule

`default_nettype wire

//--- dv/mergeTests.svh
task automatic randomizeLanes(output logic [DataW-1:0] sum);
    sum = '0;
    for (int k = 0; k < NumLanes; k++) begin
        lanes[k] = $urandom;
        sum      = sum + lanes[k];
    end
endtask

task automatic startSweep(int minDelay, output logic [DataW-1:0] sum);
    logic [1:0] resp;
    int         delay;
    delay = minDelay + int'($urandom % (21 - minDelay));  // Kept within 0 to 20.
    @(posedge clk);
    #1;
    randomizeLanes(sum);
    axiWrite(RegDelay, DataW'(delay), 4'hF, 0, resp);
    checkEq("delay write resp", RespOkay, resp);
    axiWrite(RegCtrl, 32'h1, 4'hF, 0, resp);
    checkEq("start write resp", RespOkay, resp);
endtask

// Returns one edge after the stream has dropped, so the window checks have all run.
task automatic waitSweepEnd();
    @(negedge clk);
    while (!outValid) @(negedge clk);
    while (outValid) @(negedge clk);
    @(negedge clk);
endtask

task automatic waitDoneAndCheck(logic [DataW-1:0] sum);
    logic [DataW-1:0] data;
    logic [1:0]       resp;
    data = '0;
    while (data[1] == 1'b0) begin
        axiRead(RegStatus, 0, data, resp);
    end
    checkEq("status", 32'h2, data);
    axiRead(RegCount, 0, data, resp);
    checkEq("count", 32'd16, data);
    axiRead(RegChecksum, 0, data, resp);
    checkEq("checksum", sum, data);
    checkEq("checksum resp", RespOkay, resp);
endtask

task automatic runAllTests();
    logic [DataW-1:0] data;
    logic [DataW-1:0] sum;
    logic [1:0]       resp;

    beginTest("1 reset state");
    checkEq("outValid", 32'h0, 32'(outValid));
    axiRead(RegStatus, 0, data, resp);
    checkEq("status", 32'h0, data);
    checkEq("status resp", RespOkay, resp);
    axiRead(RegCount, 0, data, resp);
    checkEq("count", 32'h0, data);
    axiRead(RegChecksum, 0, data, resp);
    checkEq("checksum", 32'h0, data);
    checkEq("checksum resp", RespOkay, resp);
    endTest();

    beginTest("2 delay register");
    axiWrite(RegDelay, 32'h1234_ABCD, 4'hF, 0, resp);
    axiRead(RegDelay, 0, data, resp);
    checkEq("full strobe", 32'h0000_ABCD, data);
    axiWrite(RegDelay, 32'h7788_5566, 4'b1010, 0, resp);
    axiRead(RegDelay, 2, data, resp);
    checkEq("partial strobe", 32'h0000_55CD, data);
    endTest();

    beginTest("3 sweep order");
    startSweep(0, sum);
    waitSweepEnd();
    endTest();

    beginTest("4 sweep status");
    waitDoneAndCheck(sum);
    endTest();

    beginTest("5 errors and back-pressure");
    axiRead(8'h20, 0, data, resp);
    checkEq("unmapped read resp", RespSlvErr, resp);
    checkEq("unmapped read data", 32'h0, data);
    axiWrite(8'h20, 32'hDEAD_BEEF, 4'hF, 5, resp);
    checkEq("unmapped write resp", RespSlvErr, resp);
    endTest();

    beginTest("6 restart");
    startSweep(10, sum);
    axiRead(RegCount, 0, data, resp);
    checkEq("cleared count", 32'h0, data);
    axiRead(RegChecksum, 0, data, resp);
    checkEq("cleared checksum", 32'h0, data);
    waitDoneAndCheck(sum);
    endTest();
endtask

//--- dv/mergeTb.sv
`timescale 1ns/1ns
`default_nettype none

module mergeTb;
    import mergePkg::*;

    localparam int TimeoutCycles = 2000;  // Six tests of about 80 cycles, with wide margin.

    logic                clk;
    logic                rst;
    axiLiteReqT          axiReq;
    axiLiteRspT          axiRsp;
    laneVecT             lanes;
    logic [DataW-1:0]    outData;
    logic                outValid;

    int                  errors;
    int                  testsPassed;
    int                  testsFailed;
    int                  errorsAtStart;
    int                  tick;
    string               curTest;

    // Reference model of the stream, armed by each accepted start write.
    int                  cyc;
    int                  firstEdge;
    logic                armed;
    logic [DelayW-1:0]   modelDelay;
    laneVecT             expWord;
    logic                inWindow;
    logic [DataW-1:0]    expWordNow;

    mergeTop dut0 (
        .clk      (clk),
        .rst      (rst),
        .axiReq   (axiReq),
        .axiRsp   (axiRsp),
        .lanes    (lanes),
        .outData  (outData),
        .outValid (outValid)
    );

    always #10 clk = ~clk;

    function automatic logic [DelayW-1:0] applyStrobes(logic [DelayW-1:0] old,
                                                       logic [DataW-1:0] data,
                                                       logic [StrbW-1:0] strb);
        logic [DelayW-1:0] merged;
        merged = old;
        if (strb[0]) merged[7:0] = data[7:0];
        if (strb[1]) merged[15:8] = data[15:8];
        return merged;
    endfunction

    // Word 0 leaves the DUT three edges plus the delay after the accepting edge.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc        <= 0;
            firstEdge  <= 0;
            armed      <= 1'b0;
            modelDelay <= '0;
            expWord    <= '0;
        end else begin
            cyc <= cyc + 1;
            if (axiReq.awvalid && axiReq.wvalid && axiRsp.awready) begin
                if (axiReq.awaddr == RegDelay) begin
                    modelDelay <= applyStrobes(modelDelay, axiReq.wdata, axiReq.wstrb);
                end
                if (axiReq.awaddr == RegCtrl && axiReq.wdata[0]) begin
                    firstEdge <= cyc + 4 + int'(modelDelay);
                    expWord   <= lanes;
                    armed     <= 1'b1;
                end
            end
        end
    end

    assign inWindow   = armed && (cyc >= firstEdge) && (cyc < firstEdge + NumLanes);
    assign expWordNow = expWord[LaneIdxW'(cyc - firstEdge)];

    validWindow: assert property (@(posedge clk) disable iff (rst) outValid == inWindow)
    else begin
        errors++;
        $display("[FAIL] %s outValid: expected %b, actual %b",
                 curTest, $sampled(inWindow), $sampled(outValid));
    end

    wordValue: assert property (@(posedge clk) disable iff (rst)
        inWindow |-> outData == expWordNow)
    else begin
        errors++;
        $display("[FAIL] %s word: expected %h, actual %h",
                 curTest, $sampled(expWordNow), $sampled(outData));
    end

    bStable: assert property (@(posedge clk) disable iff (rst)
        axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid && $stable(axiRsp.bresp))
    else begin
        errors++;
        $display("In %s the write response changed while bready was low.", curTest);
    end

    noSecondWrite: assert property (@(posedge clk) disable iff (rst)
        axiRsp.bvalid |-> !axiRsp.awready)
    else begin
        errors++;
        $display("In %s a write was accepted while a response was pending.", curTest);
    end

    writeReadyPair: assert property (@(posedge clk) disable iff (rst)
        axiRsp.wready == axiRsp.awready)
    else begin
        errors++;
        $display("In %s wready and awready disagreed.", curTest);
    end

    rStable: assert property (@(posedge clk) disable iff (rst)
        axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid && $stable(axiRsp.rdata))
    else begin
        errors++;
        $display("In %s the read response changed while rready was low.", curTest);
    end

    always @(posedge clk) begin
        tick++;
        if (tick >= TimeoutCycles) begin
            $display("Timeout: test %s did not finish within %0d cycles.", curTest, TimeoutCycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic checkEq(string what, logic [DataW-1:0] exp, logic [DataW-1:0] act);
        assert (exp === act)
        else begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", curTest, what, exp, act);
        end
    endtask

    task automatic axiWrite(logic [AddrW-1:0] addr, logic [DataW-1:0] data,
                            logic [StrbW-1:0] strb, int holdOff, output logic [1:0] resp);
        @(posedge clk);
        #1;
        axiReq.awaddr  = addr;
        axiReq.wdata   = data;
        axiReq.wstrb   = strb;
        axiReq.awvalid = 1'b1;
        axiReq.wvalid  = 1'b1;
        axiReq.bready  = (holdOff == 0);
        @(negedge clk);
        while (!axiRsp.awready) @(negedge clk);
        @(posedge clk);
        #1;
        // During a hold-off the valids stay up as a second write that must wait.
        if (holdOff == 0) begin
            axiReq.awvalid = 1'b0;
            axiReq.wvalid  = 1'b0;
        end
        repeat (holdOff) begin
            @(posedge clk);
            #1;
        end
        axiReq.awvalid = 1'b0;
        axiReq.wvalid  = 1'b0;
        axiReq.bready  = 1'b1;
        @(negedge clk);
        while (!axiRsp.bvalid) @(negedge clk);
        resp = axiRsp.bresp;
        @(posedge clk);
        #1;
        axiReq.bready = 1'b0;
    endtask

    task automatic axiRead(logic [AddrW-1:0] addr, int holdOff,
                           output logic [DataW-1:0] data, output logic [1:0] resp);
        @(posedge clk);
        #1;
        axiReq.araddr  = addr;
        axiReq.arvalid = 1'b1;
        axiReq.rready  = (holdOff == 0);
        @(negedge clk);
        while (!axiRsp.arready) @(negedge clk);
        @(posedge clk);
        #1;
        axiReq.arvalid = 1'b0;
        repeat (holdOff) begin
            @(posedge clk);
            #1;
        end
        axiReq.rready = 1'b1;
        @(negedge clk);
        while (!axiRsp.rvalid) @(negedge clk);
        data = axiRsp.rdata;
        resp = axiRsp.rresp;
        @(posedge clk);
        #1;
        axiReq.rready = 1'b0;
    endtask

    task automatic beginTest(string name);
        curTest       = name;
        errorsAtStart = errors;
    endtask

    task automatic endTest();
        if (errors == errorsAtStart) begin
            testsPassed++;
            $display("Test %s passed.", curTest);
        end else begin
            testsFailed++;
            $display("Test %s failed with %0d errors.", curTest, errors - errorsAtStart);
        end
    endtask

    `include "mergeTests.svh"

    initial begin
        void'($urandom(32'hb14f_288a));
        clk         = 1'b0;
        rst         = 1'b1;
        axiReq      = '0;
        lanes       = '0;
        errors      = 0;
        testsPassed = 0;
        testsFailed = 0;
        tick        = 0;
        curTest     = "reset";
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        runAllTests();
        $display("Tests passed %0d, failed %0d.", testsPassed, testsFailed);
        if (errors == 0 && testsFailed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+dv
rtl/mergePkg.sv
rtl/mergeRegs.sv
rtl/skewLine.sv
rtl/laneMerge.sv
rtl/sweepMonitor.sv
rtl/mergeTop.sv
dv/mergeTb.sv

//--- Bender.yml
package:
  name: mergeTop

sources:
  - files:
      - rtl/mergePkg.sv
      - rtl/mergeRegs.sv
      - rtl/skewLine.sv
      - rtl/laneMerge.sv
      - rtl/sweepMonitor.sv
      - rtl/mergeTop.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mergeTb.sv
